/* src/cmdTimerPkg.sv */
package cmdTimerPkg;

    localparam int DATA_WIDTH = 16;
    localparam int COUNT_WIDTH = 32;
    localparam int NUM_TIMERS = 4;
    localparam int TIMER_IDX_WIDTH = 2;
    localparam int OPCODE_WIDTH = 4;
    localparam int REG_DEST_WIDTH = 4;
    localparam int ADDR_WIDTH = 16;
    localparam int PRESCALE_WIDTH = 8;

    // Major opcodes seen on cmdOpcode
    localparam logic [OPCODE_WIDTH-1:0] OP_SET = 4'h0;
    localparam logic [OPCODE_WIDTH-1:0] OP_CLEAR = 4'h1;
    localparam logic [OPCODE_WIDTH-1:0] OP_CHECK = 4'h2;
    localparam logic [OPCODE_WIDTH-1:0] OP_WAIT = 4'h3;
    localparam logic [OPCODE_WIDTH-1:0] OP_CTRL = 4'h4;
    localparam logic [OPCODE_WIDTH-1:0] OP_LOAD = 4'h5;

    // Minor opcodes for the CHECK lane select, anything else reads as zero
    localparam logic [3:0] MINOR_UBYTE = 4'h0;
    localparam logic [3:0] MINOR_SBYTE = 4'h1;
    localparam logic [3:0] MINOR_UHALF = 4'h2;
    localparam logic [3:0] MINOR_SHALF = 4'h3;

    // Dispatcher state encoding
    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_ISSUE = 3'd1;
    localparam logic [2:0] ST_BUSY = 3'd2;
    localparam logic [2:0] ST_ACK = 3'd3;
    localparam logic [2:0] ST_RELEASE = 3'd4;

    typedef union packed {
        logic [COUNT_WIDTH-1:0] valueView;
        struct packed {
            logic [ADDR_WIDTH-1:0] addr;
            logic [3:0] minorOpcode;
            logic [11:0] spare;
        } accessView;
        struct packed {
            logic run;
            logic [PRESCALE_WIDTH-1:0] prescale;
            logic [22:0] spare;
        } ctrlView;
    } timerPayload_u;

endpackage

/* src/tickCounter.sv */
`timescale 1ns/1ns

module tickCounter import cmdTimerPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic runEnable,
    input  logic [PRESCALE_WIDTH-1:0] prescale,
    input  logic loadStb,
    input  logic [COUNT_WIDTH-1:0] loadValue,
    output logic [COUNT_WIDTH-1:0] count
);

    logic [PRESCALE_WIDTH-1:0] divider;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
            divider <= '0;
        end else if (loadStb) begin
            count <= loadValue;
            divider <= '0;
        end else if (runEnable) begin
            // A prescale lowered mid-period still wraps at once
            if (divider >= prescale) begin
                divider <= '0;
                count <= count + 1'b1;
            end else begin
                divider <= divider + 1'b1;
            end
        end
    end

endmodule

/* src/timerConfig.sv */
`timescale 1ns/1ns

module timerConfig import cmdTimerPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic ctrlStb,
    input  logic loadStb,
    input  timerPayload_u payload,
    output logic runEnable,
    output logic [PRESCALE_WIDTH-1:0] prescale,
    output logic counterLoadStb,
    output logic [COUNT_WIDTH-1:0] counterLoadValue
);

    // Run bit and prescale divider setting
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            runEnable <= 1'b0;
            prescale <= '0;
        end else if (ctrlStb) begin
            runEnable <= payload.ctrlView.run;
            prescale <= payload.ctrlView.prescale;
        end
    end

    // The counter sees the preload one cycle after the command strobe
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            counterLoadStb <= 1'b0;
        end else begin
            counterLoadStb <= loadStb;
        end
    end

    always_ff @(posedge clk) begin
        if (loadStb) begin
            counterLoadValue <= payload.valueView;
        end
    end

endmodule

/* src/timerCell.sv */
`timescale 1ns/1ns

module timerCell import cmdTimerPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic [COUNT_WIDTH-1:0] count,
    input  logic setStb,
    input  logic clearStb,
    input  logic checkStb,
    input  logic waitStb,
    input  timerPayload_u payload,
    input  logic [REG_DEST_WIDTH-1:0] regDest,
    output logic [COUNT_WIDTH-1:0] checkValue,
    output logic checkDone,
    output logic waitDone,
    output logic [REG_DEST_WIDTH-1:0] cellRegDest
);

    logic active;
    logic [COUNT_WIDTH-1:0] comparison;
    logic elapsed;
    logic waitPending;
    logic idleWaitDone;
    logic [COUNT_WIDTH-1:0] checkBuf;
    logic [REG_DEST_WIDTH-1:0] destBuf;

    assign elapsed = active && (count == comparison);

    // Elapsed disarms the timer on the following edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            active <= 1'b0;
            comparison <= '0;
        end else if (setStb) begin
            active <= 1'b1;
            comparison <= payload.valueView;
        end else if (clearStb || elapsed) begin
            active <= 1'b0;
        end
    end

    // A WAIT that lands on the elapsed cycle itself finishes without pending
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            waitPending <= 1'b0;
        end else if (waitStb && active && !elapsed) begin
            waitPending <= 1'b1;
        end else if (elapsed || clearStb) begin
            waitPending <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idleWaitDone <= 1'b0;
            checkDone <= 1'b0;
        end else begin
            idleWaitDone <= waitStb && !active;
            checkDone <= checkStb;
        end
    end

    assign waitDone = idleWaitDone || (elapsed && (waitPending || waitStb));

    // Signed distance to the comparison point, read back as zero when disarmed
    always_ff @(posedge clk) begin
        if (checkStb) begin
            checkBuf <= active ? (count - comparison - 1'b1) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (checkStb || waitStb) begin
            destBuf <= regDest;
        end
    end

    assign checkValue = checkBuf;
    assign cellRegDest = (checkStb || waitStb) ? regDest : destBuf;

endmodule

/* src/loadAlign.sv */
`timescale 1ns/1ns

module loadAlign import cmdTimerPkg::*; (
    input  logic [3:0] minorOpcode,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [COUNT_WIDTH-1:0] dataIn,
    output logic [DATA_WIDTH-1:0] dataOut
);

    logic [7:0] byteLane;
    logic [15:0] halfLane;

    // Lane picked by the low address bits, little endian
    assign byteLane = dataIn[addr[1:0]*8 +: 8];
    assign halfLane = addr[1] ? dataIn[31:16] : dataIn[15:0];

    always_comb begin
        case (minorOpcode)
            MINOR_UBYTE: begin
                dataOut = DATA_WIDTH'(byteLane);
            end
            MINOR_SBYTE: begin
                dataOut = DATA_WIDTH'(signed'(byteLane));
            end
            MINOR_UHALF: begin
                dataOut = DATA_WIDTH'(halfLane);
            end
            MINOR_SHALF: begin
                dataOut = DATA_WIDTH'(signed'(halfLane));
            end
            default: begin
                dataOut = '0;
            end
        endcase
    end

endmodule

/* src/timerDispatch.sv */
`timescale 1ns/1ns

module timerDispatch import cmdTimerPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic cmdReq,
    input  logic [OPCODE_WIDTH-1:0] cmdOpcode,
    input  logic [TIMER_IDX_WIDTH-1:0] cmdTimer,
    input  logic [REG_DEST_WIDTH-1:0] cmdRegDest,
    input  timerPayload_u cmdPayload,
    output logic cmdAck,
    output logic [DATA_WIDTH-1:0] rspData,
    output logic [REG_DEST_WIDTH-1:0] rspRegDest,
    output logic [NUM_TIMERS-1:0] setStb,
    output logic [NUM_TIMERS-1:0] clearStb,
    output logic [NUM_TIMERS-1:0] checkStb,
    output logic [NUM_TIMERS-1:0] waitStb,
    output logic ctrlStb,
    output logic loadStb,
    output timerPayload_u payload,
    output logic [REG_DEST_WIDTH-1:0] regDest,
    output logic [TIMER_IDX_WIDTH-1:0] timerIdx,
    input  logic [NUM_TIMERS-1:0] checkDone,
    input  logic [NUM_TIMERS-1:0] waitDone,
    input  logic [DATA_WIDTH-1:0] alignedData,
    input  logic [NUM_TIMERS-1:0][REG_DEST_WIDTH-1:0] cellRegDest
);

    logic [2:0] state;
    logic [OPCODE_WIDTH-1:0] opcode;
    logic accept;
    logic issue;
    logic selDone;
    logic capture;
    logic [NUM_TIMERS-1:0] timerSel;

    assign accept = (state == ST_IDLE) && cmdReq;
    assign issue = (state == ST_ISSUE);
    assign timerSel = NUM_TIMERS'(1) << timerIdx;

    assign setStb = (issue && opcode == OP_SET) ? timerSel : '0;
    assign clearStb = (issue && opcode == OP_CLEAR) ? timerSel : '0;
    assign checkStb = (issue && opcode == OP_CHECK) ? timerSel : '0;
    assign waitStb = (issue && opcode == OP_WAIT) ? timerSel : '0;
    assign ctrlStb = issue && (opcode == OP_CTRL);
    assign loadStb = issue && (opcode == OP_LOAD);

    // Only CHECK and WAIT wait on a cell, the rest finish in the strobe cycle
    always_comb begin
        case (opcode)
            OP_CHECK: selDone = checkDone[timerIdx];
            OP_WAIT: selDone = waitDone[timerIdx];
            default: selDone = 1'b1;
        endcase
    end

    assign capture = (issue || state == ST_BUSY) && selDone;
    assign cmdAck = (state == ST_ACK);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= ST_IDLE;
            opcode <= '0;
            timerIdx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmdReq) begin
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE, ST_BUSY: begin
                    state <= selDone ? ST_ACK : ST_BUSY;
                end
                ST_ACK: begin
                    if (!cmdReq) begin
                        state <= ST_RELEASE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
            if (accept) begin
                opcode <= cmdOpcode;
                timerIdx <= cmdTimer;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            payload <= cmdPayload;
            regDest <= cmdRegDest;
        end
    end

    // Response stays frozen through the whole ack phase
    always_ff @(posedge clk) begin
        if (capture) begin
            rspData <= (opcode == OP_CHECK) ? alignedData : '0;
            if (opcode == OP_CHECK || opcode == OP_WAIT) begin
                rspRegDest <= cellRegDest[timerIdx];
            end else begin
                rspRegDest <= regDest;
            end
        end
    end

endmodule

/* src/commandTimers.sv */
`timescale 1ns/1ns

module commandTimers import cmdTimerPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic cmdReq,
    input  logic [OPCODE_WIDTH-1:0] cmdOpcode,
    input  logic [TIMER_IDX_WIDTH-1:0] cmdTimer,
    input  logic [REG_DEST_WIDTH-1:0] cmdRegDest,
    input  timerPayload_u cmdPayload,
    output logic cmdAck,
    output logic [DATA_WIDTH-1:0] rspData,
    output logic [REG_DEST_WIDTH-1:0] rspRegDest
);

    logic [NUM_TIMERS-1:0] setStb;
    logic [NUM_TIMERS-1:0] clearStb;
    logic [NUM_TIMERS-1:0] checkStb;
    logic [NUM_TIMERS-1:0] waitStb;
    logic ctrlStb;
    logic loadStb;
    timerPayload_u payload;
    logic [REG_DEST_WIDTH-1:0] regDest;
    logic [TIMER_IDX_WIDTH-1:0] timerIdx;
    logic [NUM_TIMERS-1:0] checkDone;
    logic [NUM_TIMERS-1:0] waitDone;
    logic [NUM_TIMERS-1:0][REG_DEST_WIDTH-1:0] cellRegDest;
    logic [NUM_TIMERS-1:0][COUNT_WIDTH-1:0] checkValue;
    logic [DATA_WIDTH-1:0] alignedData;
    logic runEnable;
    logic [PRESCALE_WIDTH-1:0] prescale;
    logic counterLoadStb;
    logic [COUNT_WIDTH-1:0] counterLoadValue;
    logic [COUNT_WIDTH-1:0] count;

    timerDispatch dispatch_inst (
        .clk(clk), .arstN(arstN),
        .cmdReq(cmdReq), .cmdOpcode(cmdOpcode), .cmdTimer(cmdTimer),
        .cmdRegDest(cmdRegDest), .cmdPayload(cmdPayload),
        .cmdAck(cmdAck), .rspData(rspData), .rspRegDest(rspRegDest),
        .setStb(setStb), .clearStb(clearStb), .checkStb(checkStb), .waitStb(waitStb),
        .ctrlStb(ctrlStb), .loadStb(loadStb),
        .payload(payload), .regDest(regDest), .timerIdx(timerIdx),
        .checkDone(checkDone), .waitDone(waitDone),
        .alignedData(alignedData), .cellRegDest(cellRegDest)
    );

    timerConfig config_inst (
        .clk(clk), .arstN(arstN),
        .ctrlStb(ctrlStb), .loadStb(loadStb), .payload(payload),
        .runEnable(runEnable), .prescale(prescale),
        .counterLoadStb(counterLoadStb), .counterLoadValue(counterLoadValue)
    );

    tickCounter counter_inst (
        .clk(clk), .arstN(arstN),
        .runEnable(runEnable), .prescale(prescale),
        .loadStb(counterLoadStb), .loadValue(counterLoadValue),
        .count(count)
    );

    for (genvar i = 0; i < NUM_TIMERS; i++) begin : cellGen
        timerCell cell_inst (
            .clk(clk), .arstN(arstN), .count(count),
            .setStb(setStb[i]), .clearStb(clearStb[i]),
            .checkStb(checkStb[i]), .waitStb(waitStb[i]),
            .payload(payload), .regDest(regDest),
            .checkValue(checkValue[i]), .checkDone(checkDone[i]),
            .waitDone(waitDone[i]), .cellRegDest(cellRegDest[i])
        );
    end

    // Selected cell's buffered difference goes through the lane select
    loadAlign align_inst (
        .minorOpcode(payload.accessView.minorOpcode),
        .addr(payload.accessView.addr),
        .dataIn(checkValue[timerIdx]),
        .dataOut(alignedData)
    );

endmodule

/* test/clockGen.sv */
`timescale 1ns/1ns

module clockGen (
    output logic clk,
    output logic arstN
);

    localparam int HALF_PERIOD_NS = 20;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

    initial begin
        arstN <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

/* test/commandTimersTb.sv */
`timescale 1ns/1ns

module commandTimersTb import cmdTimerPkg::*; ();

    localparam int MAX_LINES = 64;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLES_PER_LINE = 300;

    logic clk;
    logic arstN;
    logic cmdReq;
    logic [OPCODE_WIDTH-1:0] cmdOpcode;
    logic [TIMER_IDX_WIDTH-1:0] cmdTimer;
    logic [REG_DEST_WIDTH-1:0] cmdRegDest;
    timerPayload_u cmdPayload;
    logic cmdAck;
    logic [DATA_WIDTH-1:0] rspData;
    logic [REG_DEST_WIDTH-1:0] rspRegDest;

    // One command per entry as laid out in the column line of the stimulus file
    logic [67:0] stimMem [0:MAX_LINES-1];
    int numLines;
    int cycleCount = 0;
    int cycleLimit = 0;

    clockGen clockGen_inst (
        .clk(clk),
        .arstN(arstN)
    );

    commandTimers commandTimers_inst (
        .clk(clk), .arstN(arstN),
        .cmdReq(cmdReq), .cmdOpcode(cmdOpcode), .cmdTimer(cmdTimer),
        .cmdRegDest(cmdRegDest), .cmdPayload(cmdPayload),
        .cmdAck(cmdAck), .rspData(rspData), .rspRegDest(rspRegDest)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    // CHECK buffers its difference and an idle WAIT registers its done, so both take a cycle more
    function automatic int fixedLatency(input logic [3:0] opcode);
        if (opcode == OP_CHECK || opcode == OP_WAIT) begin
            return 3;
        end else begin
            return 2;
        end
    endfunction

    task automatic compareResponse(input int lineNo, input logic [DATA_WIDTH-1:0] expData,
        input logic [3:0] expDest);
        assert (rspData == expData)
            else abortRun($sformatf("FAILED rspData on line %0d: expected %h, got %h",
                lineNo, expData, rspData));
        assert (rspRegDest == expDest)
            else abortRun($sformatf("FAILED rspRegDest on line %0d: expected %h, got %h",
                lineNo, expDest, rspRegDest));
    endtask

    task automatic runCommand(input logic [67:0] line, input int lineNo);
        logic [3:0] opcode;
        logic [DATA_WIDTH-1:0] expData;
        logic [3:0] expDest;
        logic [3:0] waitFlag;
        int waited;
        opcode = line[67:64];
        expData = line[23:8];
        expDest = line[7:4];
        waitFlag = line[3:0];
        @(posedge clk);
        cmdOpcode <= opcode;
        cmdTimer <= line[61:60];
        cmdRegDest <= line[59:56];
        cmdPayload <= line[55:24];
        cmdReq <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!cmdAck) begin
            waited++;
            @(negedge clk);
        end
        if (waitFlag == 4'h0) begin
            assert (waited == fixedLatency(opcode))
                else abortRun($sformatf("Line %0d: ack came after %0d cycles instead of %0d",
                    lineNo, waited, fixedLatency(opcode)));
        end
        compareResponse(lineNo, expData, expDest);
        // The response has to stay put while the request is held high
        @(posedge clk);
        @(negedge clk);
        assert (cmdAck)
            else abortRun($sformatf("Line %0d: ack dropped while the request stayed high",
                lineNo));
        compareResponse(lineNo, expData, expDest);
        @(posedge clk);
        cmdReq <= 1'b0;
        @(negedge clk);
        while (cmdAck) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            abortRun($sformatf("Timeout after %0d cycles before the command list finished",
                cycleCount));
        end
    end

    initial begin
        cmdReq <= 1'b0;
        cmdOpcode <= '0;
        cmdTimer <= '0;
        cmdRegDest <= '0;
        cmdPayload <= '0;
        $readmemh("test/timerStimulus.mem", stimMem);
        numLines = 0;
        while (numLines < MAX_LINES && stimMem[numLines][67:64] != 4'hF) begin
            numLines++;
        end
        assert (numLines > 0 && numLines < MAX_LINES)
            else abortRun("Stimulus file is empty or lacks its end marker line");
        cycleLimit = numLines * CYCLES_PER_LINE + RESET_CYCLES;
        @(posedge arstN);
        @(negedge clk);
        assert (cmdAck == 1'b0)
            else abortRun($sformatf("FAILED cmdAck after reset: expected 0, got %h", cmdAck));
        for (int i = 0; i < numLines; i++) begin
            runCommand(stimMem[i], i);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* commandTimers.f */
src/cmdTimerPkg.sv
src/tickCounter.sv
src/timerConfig.sv
src/timerCell.sv
src/loadAlign.sv
src/timerDispatch.sv
src/commandTimers.sv
test/clockGen.sv
test/commandTimersTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = commandTimersTb
FILELIST = commandTimers.f
OBJ_DIR = obj_dir
PASS_MSG = RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/timerStimulus.mem */
// opcode_timer_regDest_payload_expectedData_expectedRegDest_waitFlag
// waitFlag 1 marks a WAIT blocked on a running timer, opcode F ends the list
2_2_5_00000000_0000_5_0
4_0_1_00000000_0000_1_0
5_0_2_40000000_0000_2_0
0_0_3_9A3C817E_0000_3_0
2_0_4_00000000_0081_4_0
2_0_5_00010000_007E_5_0
2_0_6_ABC60000_00C3_6_0
2_0_7_00030000_00A5_7_0
2_0_8_00001000_FF81_8_0
2_0_9_00011000_007E_9_0
2_0_A_00021000_FFC3_A_0
2_0_B_00031000_FFA5_B_0
2_0_C_00002000_7E81_C_0
2_0_D_00022000_A5C3_D_0
2_0_E_00003000_7E81_E_0
2_0_F_00033000_A5C3_F_0
0_1_1_3FFFEDCB_0000_1_0
1_0_2_00000000_0000_2_0
2_0_3_00002000_0000_3_0
2_1_4_00002000_1234_4_0
2_1_5_00004000_0000_5_0
2_1_6_0002F000_0000_6_0
3_2_7_00000000_0000_7_0
5_0_8_00000100_0000_8_0
0_3_9_00000108_0000_9_0
4_0_A_81000000_0000_A_0
3_3_B_00000000_0000_B_1
2_3_C_00002000_0000_C_0
F_0_0_00000000_0000_0_0
